// File: mulUnit.f
+incdir+testbench
rtl/mulOpPkg.sv
rtl/mulWbPkg.sv
rtl/mulOperandStage.sv
rtl/mulIterCore.sv
rtl/mulResultStage.sv
rtl/mulUnit.sv
testbench/mulUnitTb.sv

// File: Bender.yml
package:
  name: mulUnit

sources:
  # packages first, the stages import them
  - rtl/mulOpPkg.sv
  - rtl/mulWbPkg.sv
  # pipeline stages and top level
  - rtl/mulOperandStage.sv
  - rtl/mulIterCore.sv
  - rtl/mulResultStage.sv
  - rtl/mulUnit.sv
  # testbench, helper header lives next to it
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/mulUnitTb.sv

// File: testbench/mulUnitTbLib.svh
// testbench helpers for the multiply unit
// LFSR random source, reference product, result and count checks

`ifndef MUL_UNIT_TB_LIB_SVH
`define MUL_UNIT_TB_LIB_SVH

// ======================================================================
// random source
// ======================================================================

// 32 bit Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
function automatic logic [WID-1:0] takeBits(inout logic [31:0] state, input int n);
	logic [WID-1:0] bits;
	logic           fb;
	bits = '0;
	for (int i = 0; i < n; i++) begin
		fb    = state[31] ^ state[21] ^ state[1] ^ state[0];
		state = {state[30:0], fb};
		bits  = {bits[WID-2:0], fb};
	end
	return bits;
endfunction

// full width random operand
function automatic logic [WID-1:0] rnd();
	return takeBits(stimState, WID);
endfunction

// ======================================================================
// reference model
// ======================================================================

// double width product by sign or zero extension of both operands
function automatic logic [2*WID-1:0] refProduct(input mulOp_t op,
		input logic [WID-1:0] a, input logic [WID-1:0] b, input logic [WID-1:0] imm);
	logic [WID-1:0]          m;
	logic signed [2*WID-1:0] x;
	logic signed [2*WID-1:0] y;
	m = (op == MULI_UU || op == MULI_SS) ? imm : b;
	if (op == MUL_SS || op == MULI_SS) begin
		x = {{WID{a[WID-1]}}, a};
		y = {{WID{m[WID-1]}}, m};
	end else begin
		x = {{WID{1'b0}}, a};
		y = {{WID{1'b0}}, m};
	end
	// low half of the wide product is exact for both cases
	return x * y;
endfunction

// ======================================================================
// checks and reporting
// ======================================================================

task automatic checkResult(input logic [2*WID-1:0] expVal, input logic [TAG_W-1:0] expTag);
	numChecks++;
	if (wbResult !== expVal) begin
		$display("** Error %s: result expected %h actual %h", curTest, expVal, wbResult);
		errorCount++;
	end
	if (wbTag !== expTag) begin
		$display("** Error %s: tag expected %0d actual %0d", curTest, expTag, wbTag);
		errorCount++;
	end
endtask

task automatic expectCount(input string what, input int expected, input int actual);
	numChecks++;
	if (actual != expected) begin
		$display("** Error %s: %s expected %0d actual %0d", curTest, what, expected, actual);
		errorCount++;
	end
endtask

task automatic startTest(input string name);
	curTest         = name;
	testStartChecks = numChecks;
	testStartErrors = errorCount;
endtask

task automatic endTest();
	$display("test %s finished: %0d checks, %0d errors", curTest,
		numChecks - testStartChecks, errorCount - testStartErrors);
endtask

`endif

// File: testbench/mulUnitTb.sv
// testbench for the multiply unit
// clock, reset, stimulus, writeback credit model, result compare, watchdog

`timescale 1ns/1ps

module mulUnitTb import mulOpPkg::*, mulWbPkg::*;;

	localparam int WID          = DEFAULT_WID;
	localparam int TAG_W        = DEFAULT_TAG_W;
	localparam int CREDITS      = DEFAULT_CREDITS;
	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 16;
	// operations per test
	localparam int DIRECT_OPS   = 8;
	localparam int RAND_OPS     = 20;
	localparam int BURST_OPS    = 16;
	localparam int STALL_OPS    = 10;
	localparam int TOTAL_OPS    = 2 * CREDITS + 4 + STALL_OPS
		+ 2 * (DIRECT_OPS + RAND_OPS) + BURST_OPS;
	// credit returns lag a result by zero to three cycles
	localparam int MAX_CREDIT_DELAY = 3;
	localparam int HOLD_CYCLES      = 60;
	localparam int DRAIN_LIMIT      = 200;
	localparam int MARGIN           = 500;
	localparam int WATCHDOG_CYCLES  = RESET_CYCLES + TOTAL_OPS * (STEPS + 2)
		+ MAX_CREDIT_DELAY + 3 * HOLD_CYCLES + MARGIN;
	localparam logic [WID-1:0] MIN_VAL = {1'b1, {(WID-1){1'b0}}};
	localparam logic [WID-1:0] MAX_VAL = ~MIN_VAL;
	// operand for the unused multiplier source
	localparam logic [WID-1:0] FILL    = {(WID/4){4'ha}};

	logic               clk;
	logic               rst;
	logic               abort;
	logic               issueValid;
	mulOp_t             issueOp;
	logic [WID-1:0]     issueA;
	logic [WID-1:0]     issueB;
	logic [WID-1:0]     issueImm;
	logic [TAG_W-1:0]   issueTag;
	logic               wbCredit = 1'b0;
	logic               issueReady;
	logic               wbValid;
	logic [2*WID-1:0]   wbResult;
	logic [TAG_W-1:0]   wbTag;

	// expected results in issue order
	logic [2*WID-1:0]   expResultQ[$];
	logic [TAG_W-1:0]   expTagQ[$];
	logic [31:0]        stimState       = 32'h80547ff4;
	logic [31:0]        creditState     = 32'h80547ff4;
	logic [TAG_W-1:0]   nextTag         = '0;
	logic               holdCredits     = 1'b0;
	string              curTest         = "none";
	int                 numChecks       = 0;
	int                 errorCount      = 0;
	int                 testStartChecks = 0;
	int                 testStartErrors = 0;
	int                 received        = 0;
	int                 outstanding     = 0;
	int                 creditDelay     = 0;
	int                 maxInFlight     = 0;
	int                 flushed;

	`include "mulUnitTbLib.svh"

	mulUnit mulUnit_inst (
		.clk, .rst, .abort,
		.issueValid, .issueOp, .issueA, .issueB, .issueImm, .issueTag,
		.wbCredit, .issueReady, .wbValid, .wbResult, .wbTag
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ======================================================================
	// stimulus tasks
	// ======================================================================

	// present one operation and wait for the edge that accepts it
	task automatic issueOne(input mulOp_t op, input logic [WID-1:0] a,
			input logic [WID-1:0] b, input logic [WID-1:0] imm);
		issueValid <= 1'b1;
		issueOp    <= op;
		issueA     <= a;
		issueB     <= b;
		issueImm   <= imm;
		issueTag   <= nextTag;
		@(posedge clk);
		while (!issueReady) begin
			@(posedge clk);
		end
		expResultQ.push_back(refProduct(op, a, b, imm));
		expTagQ.push_back(nextTag);
		nextTag = nextTag + 1'b1;
		if (expResultQ.size() > maxInFlight)
			maxInFlight = expResultQ.size();
	endtask

	// kind 0 unsigned only, 1 signed only, 2 any operation
	task automatic issueRandom(input int kind);
		logic [1:0]     sel;
		logic [WID-1:0] a;
		logic [WID-1:0] b;
		logic [WID-1:0] imm;
		sel = 2'(takeBits(stimState, 2));
		if (kind == 0)
			sel[0] = 1'b0;
		else if (kind == 1)
			sel[0] = 1'b1;
		a   = rnd();
		b   = rnd();
		imm = rnd();
		issueOne(mulOp_t'(sel), a, b, imm);
	endtask

	task automatic issueIdle();
		issueValid <= 1'b0;
	endtask

	// wait for every result and every credit to come home
	task automatic drain(input int limit);
		int waited;
		waited = 0;
		while ((expResultQ.size() != 0 || outstanding != 0) && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		if (expResultQ.size() != 0 || outstanding != 0) begin
			$display("%s: %0d results still missing after %0d cycles", curTest,
				expResultQ.size(), limit);
			errorCount++;
		end
		repeat (2) @(posedge clk);
	endtask

	// withhold credits over a burst, then release them and drain
	task automatic stallCheck(input int nOps);
		int base;
		base        = received;
		holdCredits = 1'b1;
		fork
			begin
				for (int i = 0; i < nOps; i++) begin
					issueRandom(2);
				end
				issueIdle();
			end
			begin
				repeat (HOLD_CYCLES) @(negedge clk);
				expectCount("results while credits held", CREDITS, received - base);
				holdCredits = 1'b0;
			end
		join
		drain(DRAIN_LIMIT);
		expectCount("results after credit release", nOps, received - base);
	endtask

	// ======================================================================
	// writeback model and compare
	// ======================================================================

	// slots fill on each result, one credit returned per cycle at most
	always @(posedge clk) begin
		if (rst) begin
			wbCredit <= 1'b0;
			creditDelay = 0;
		end else begin
			if (wbValid === 1'b1) begin
				outstanding++;
				if (outstanding > CREDITS) begin
					$display("%s: writeback holds %0d results but owns only %0d slots",
						curTest, outstanding, CREDITS);
					errorCount++;
				end
			end
			if (!holdCredits && outstanding > 0 && creditDelay == 0) begin
				wbCredit <= 1'b1;
				outstanding--;
				creditDelay = int'(takeBits(creditState, 2));
			end else begin
				wbCredit <= 1'b0;
				if (creditDelay > 0)
					creditDelay--;
			end
		end
	end

	always @(posedge clk) begin
		if (!rst && wbValid === 1'b1) begin
			received++;
			if (expResultQ.size() == 0) begin
				$display("%s: result with tag %0d arrived with nothing expected",
					curTest, wbTag);
				errorCount++;
			end else begin
				checkResult(expResultQ.pop_front(), expTagQ.pop_front());
			end
		end
	end

	// ======================================================================
	// test sequence
	// ======================================================================

	initial begin
		rst        <= 1'b1;
		abort      <= 1'b0;
		issueValid <= 1'b0;
		issueOp    <= MUL_UU;
		issueA     <= '0;
		issueB     <= '0;
		issueImm   <= '0;
		issueTag   <= '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);

		startTest("resetState");
		@(negedge clk);
		numChecks += 2;
		if (wbValid !== 1'b0) begin
			$display("%s: wbValid is not low after reset", curTest);
			errorCount++;
		end
		if (issueReady !== 1'b1) begin
			$display("%s: issueReady is not high after reset", curTest);
			errorCount++;
		end
		@(posedge clk);
		// full credit pool goes out with no returns
		stallCheck(CREDITS);
		endTest();

		startTest("unsignedOps");
		issueOne(MUL_UU, '0, rnd(), FILL);
		issueOne(MULI_UU, rnd(), FILL, '0);
		issueOne(MUL_UU, '1, '1, FILL);
		issueOne(MULI_UU, '1, FILL, '1);
		issueOne(MUL_UU, MIN_VAL, MIN_VAL, FILL);
		issueOne(MUL_UU, WID'(1), rnd(), FILL);
		issueOne(MULI_UU, WID'(1) << 17, FILL, WID'(1) << 40);
		issueOne(MUL_UU, '1, WID'(1), FILL);
		for (int i = 0; i < RAND_OPS; i++)
			issueRandom(0);
		issueIdle();
		drain(DRAIN_LIMIT);
		endTest();

		startTest("signedOps");
		issueOne(MUL_SS, WID'(-3), WID'(5), FILL);
		issueOne(MUL_SS, WID'(7), WID'(-9), FILL);
		issueOne(MUL_SS, MIN_VAL, MIN_VAL, FILL);
		issueOne(MUL_SS, MIN_VAL, '1, FILL);
		issueOne(MULI_SS, '1, FILL, '1);
		issueOne(MULI_SS, MIN_VAL, FILL, WID'(1));
		issueOne(MUL_SS, MAX_VAL, MIN_VAL, FILL);
		issueOne(MULI_SS, rnd(), FILL, '1);
		for (int i = 0; i < RAND_OPS; i++)
			issueRandom(1);
		issueIdle();
		drain(DRAIN_LIMIT);
		endTest();

		startTest("backToBack");
		maxInFlight = 0;
		for (int i = 0; i < BURST_OPS; i++)
			issueRandom(2);
		issueIdle();
		drain(DRAIN_LIMIT);
		numChecks++;
		if (maxInFlight < 3) begin
			$display("%s: only %0d operations were in flight at once", curTest, maxInFlight);
			errorCount++;
		end
		endTest();

		startTest("creditStall");
		stallCheck(STALL_OPS);
		endTest();

		startTest("abortFlush");
		issueRandom(2);
		issueRandom(2);
		issueIdle();
		repeat (2) @(posedge clk);
		abort <= 1'b1;
		@(posedge clk);
		// both operations die in the pipe
		flushed = expResultQ.size();
		expResultQ.delete();
		expTagQ.delete();
		abort <= 1'b0;
		expectCount("operations flushed by abort", 2, flushed);
		// a full credit pool afterwards shows the count survived
		stallCheck(CREDITS + 2);
		endTest();

		$display("%0d checks, %0d errors, %0d results received",
			numChecks, errorCount, received);
		if (errorCount == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// budget from the op count, credit delay and hold windows
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles in test %s", WATCHDOG_CYCLES, curTest);
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: rtl/mulUnit.sv
// multiply functional unit top level
// operand stage, iterative core and result stage in a chain

`timescale 1ns/1ps

module mulUnit import mulOpPkg::*, mulWbPkg::*; #(
	parameter int WID     = DEFAULT_WID,
	parameter int TAG_W   = DEFAULT_TAG_W,
	parameter int CREDITS = DEFAULT_CREDITS
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               abort,
	input  logic               issueValid,
	input  mulOp_t             issueOp,
	input  logic [WID-1:0]     issueA,
	input  logic [WID-1:0]     issueB,
	input  logic [WID-1:0]     issueImm,
	input  logic [TAG_W-1:0]   issueTag,
	input  logic               wbCredit,
	output logic               issueReady,
	output logic               wbValid,
	output logic [2*WID-1:0]   wbResult,
	output logic [TAG_W-1:0]   wbTag
);

	// operand stage to core
	logic             opValid;
	logic             opReady;
	logic [WID-1:0]   aMag;
	logic [WID-1:0]   bMag;
	logic             negResult;
	logic [TAG_W-1:0] opTag;

	// core to result stage
	logic             prodValid;
	logic             prodReady;
	logic [2*WID-1:0] prod;
	logic             prodNeg;
	logic [TAG_W-1:0] prodTag;

	// ======================================================================
	// stages
	// ======================================================================

	mulOperandStage #(.WID(WID), .TAG_W(TAG_W)) operandStage_inst (
		.clk, .rst, .abort,
		.issueValid, .issueOp, .issueA, .issueB, .issueImm, .issueTag,
		.opReady, .issueReady,
		.opValid, .aMag, .bMag, .negResult, .opTag
	);

	mulIterCore #(.WID(WID), .TAG_W(TAG_W)) iterCore_inst (
		.clk, .rst, .abort,
		.opValid, .aMag, .bMag, .negResult, .opTag, .opReady,
		.prodReady, .prodValid, .prod, .prodNeg, .prodTag
	);

	mulResultStage #(.WID(WID), .TAG_W(TAG_W), .CREDITS(CREDITS)) resultStage_inst (
		.clk, .rst, .abort,
		.prodValid, .prod, .prodNeg, .prodTag, .prodReady,
		.wbCredit, .wbValid, .wbResult, .wbTag
	);

endmodule

// File: rtl/mulResultStage.sv
// result stage of the multiply unit
// sign restore, output register and writeback credit counter

`timescale 1ns/1ps

module mulResultStage import mulWbPkg::*; #(
	parameter int WID,
	parameter int TAG_W,
	parameter int CREDITS
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               abort,
	input  logic               prodValid,
	input  logic [2*WID-1:0]   prod,
	input  logic               prodNeg,
	input  logic [TAG_W-1:0]   prodTag,
	input  logic               wbCredit,
	output logic               prodReady,
	output logic               wbValid,
	output logic [2*WID-1:0]   wbResult,
	output logic [TAG_W-1:0]   wbTag
);

	logic         full;
	logic         take;
	creditCount_t creditCnt;

	// ======================================================================
	// handshake
	// ======================================================================

	// send whenever a result is held and a slot is free downstream
	assign wbValid = full && (creditCnt != '0) && !abort;

	// empty, or emptied by the send in this cycle
	assign prodReady = !full || wbValid;
	assign take      = prodValid && prodReady;

	// ======================================================================
	// output register
	// ======================================================================

	always_ff @(posedge clk) begin
		if (rst || abort) begin
			full <= 1'b0;
		end else if (take) begin
			full <= 1'b1;
		end else if (wbValid) begin
			full <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			// two's complement of the magnitude product
			wbResult <= prodNeg ? -prod : prod;
			wbTag    <= prodTag;
		end
	end

	// ======================================================================
	// credit counter
	// ======================================================================

	// kept across abort, slots downstream are still owned
	always_ff @(posedge clk) begin
		if (rst) begin
			creditCnt <= creditCount_t'(CREDITS);
		end else begin
			case ({wbValid, wbCredit})
				2'b10: creditCnt <= creditCnt - creditCount_t'(1);
				2'b01: creditCnt <= creditCnt + creditCount_t'(1);
				// send and return together cancel
				default: creditCnt <= creditCnt;
			endcase
		end
	end

	creditBound: assert property (@(posedge clk) disable iff (rst)
		creditCnt <= creditCount_t'(CREDITS));

	// writeback side never returns a slot it was not given
	noExtraReturn: assert property (@(posedge clk) disable iff (rst)
		((creditCnt == creditCount_t'(CREDITS)) && !wbValid) |-> !wbCredit);

endmodule

// File: rtl/mulIterCore.sv
// iterative multiply core
// shift and add over quarters of the multiplicand, STEPS steps
// per product, product held until the result stage takes it

`timescale 1ns/1ps

module mulIterCore import mulOpPkg::*; #(
	parameter int WID,
	parameter int TAG_W
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               abort,
	input  logic               opValid,
	input  logic [WID-1:0]     aMag,
	input  logic [WID-1:0]     bMag,
	input  logic               negResult,
	input  logic [TAG_W-1:0]   opTag,
	input  logic               prodReady,
	output logic               opReady,
	output logic               prodValid,
	output logic [2*WID-1:0]   prod,
	output logic               prodNeg,
	output logic [TAG_W-1:0]   prodTag
);

	// digit width and the width of one step sum
	localparam int Q     = WID / 4;
	localparam int SUM_W = WID + Q;
	localparam int CNT_W = $clog2(STEPS + 1);

	logic [WID-1:0]   mcand;
	logic [WID-1:0]   mplier;
	logic [2*WID-1:0] acc;
	logic [CNT_W-1:0] stepCnt;
	logic [SUM_W-1:0] stepSum;
	logic             running;
	logic             load;

	// ======================================================================
	// handshake
	// ======================================================================

	assign running = (stepCnt != '0);

	// idle, or handing the finished product on in this cycle
	assign opReady = (!running && !prodValid) || (prodValid && prodReady);
	assign load    = opValid && opReady;

	// ======================================================================
	// datapath
	// ======================================================================

	// full multiplier times low digit, plus upper half of the partial product
	assign stepSum = SUM_W'(mplier) * SUM_W'(mcand[Q-1:0]) + SUM_W'(acc[2*WID-1:WID]);

	always_ff @(posedge clk) begin
		if (load) begin
			mcand   <= aMag;
			mplier  <= bMag;
			acc     <= '0;
			prodNeg <= negResult;
			prodTag <= opTag;
		end else if (running) begin
			// next digit moves into the low quarter
			mcand <= mcand >> Q;
			// partial product slides down one digit, step sum on top
			acc   <= {stepSum, acc[WID-1:Q]};
		end
	end

	assign prod = acc;

	// ======================================================================
	// step counter and product valid
	// ======================================================================

	always_ff @(posedge clk) begin
		if (rst || abort) begin
			stepCnt   <= '0;
			prodValid <= 1'b0;
		end else begin
			if (load) begin
				stepCnt <= CNT_W'(STEPS);
			end else if (running) begin
				stepCnt <= stepCnt - CNT_W'(1);
			end
			// last step lands in the same edge that raises valid
			if (running && (stepCnt == CNT_W'(1))) begin
				prodValid <= 1'b1;
			end else if (prodValid && prodReady) begin
				prodValid <= 1'b0;
			end
		end
	end

	// a finished product never overlaps an active step count
	noValidWhileRunning: assert property (@(posedge clk) disable iff (rst)
		prodValid |-> !running);

	// stalled product keeps its value
	prodHeld: assert property (@(posedge clk) disable iff (rst)
		(prodValid && !prodReady && !abort) |=> (prodValid && $stable(prod)));

endmodule

// File: rtl/mulOperandStage.sv
// operand stage of the multiply unit
// picks the multiplier source, takes magnitudes for signed ops
// and records the sign of the result

`timescale 1ns/1ps

module mulOperandStage import mulOpPkg::*; #(
	parameter int WID,
	parameter int TAG_W
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             abort,
	input  logic             issueValid,
	input  mulOp_t           issueOp,
	input  logic [WID-1:0]   issueA,
	input  logic [WID-1:0]   issueB,
	input  logic [WID-1:0]   issueImm,
	input  logic [TAG_W-1:0] issueTag,
	input  logic             opReady,
	output logic             issueReady,
	output logic             opValid,
	output logic [WID-1:0]   aMag,
	output logic [WID-1:0]   bMag,
	output logic             negResult,
	output logic [TAG_W-1:0] opTag
);

	logic           isImm;
	logic           isSigned;
	logic [WID-1:0] multSel;
	logic [WID-1:0] aAbs;
	logic [WID-1:0] bAbs;
	logic           take;

	// ======================================================================
	// decode and operand conditioning
	// ======================================================================

	assign isImm    = (issueOp == MULI_UU) || (issueOp == MULI_SS);
	assign isSigned = (issueOp == MUL_SS) || (issueOp == MULI_SS);

	// immediate forms replace the second register
	assign multSel = isImm ? issueImm : issueB;

	// most negative value maps to its unsigned magnitude
	assign aAbs = (isSigned && issueA[WID-1]) ? -issueA : issueA;
	assign bAbs = (isSigned && multSel[WID-1]) ? -multSel : multSel;

	// free slot, or the slot drains this cycle; nothing enters during abort
	assign issueReady = (!opValid || opReady) && !abort;
	assign take       = issueValid && issueReady;

	// ======================================================================
	// stage register
	// ======================================================================

	always_ff @(posedge clk) begin
		if (rst || abort) begin
			opValid <= 1'b0;
		end else if (issueReady) begin
			opValid <= issueValid;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			aMag      <= aAbs;
			bMag      <= bAbs;
			// result negative when exactly one operand is negative
			negResult <= isSigned && (issueA[WID-1] ^ multSel[WID-1]);
			opTag     <= issueTag;
		end
	end

	// held operation stays put until the core takes it
	holdUntilTaken: assert property (@(posedge clk) disable iff (rst)
		(opValid && !opReady && !abort) |=> opValid);

endmodule

// File: rtl/mulWbPkg.sv
// writeback side definitions
// tag width default, credit default and credit counter sizing

package mulWbPkg;

	// destination tag width
	localparam int DEFAULT_TAG_W = 6;

	// result slots owned by the writeback side
	localparam int DEFAULT_CREDITS = 4;

	// counter must hold every value from zero to the full credit count
	localparam int CREDIT_W = $clog2(DEFAULT_CREDITS + 1);

	typedef logic [CREDIT_W-1:0] creditCount_t;

endpackage

// File: rtl/mulOpPkg.sv
// operation encoding for the multiply unit
// operand width default and the iteration count of the core

package mulOpPkg;

	// ======================================================================
	// operation encoding
	// ======================================================================

	// bit 0 selects signed, bit 1 selects the immediate as multiplier
	typedef enum logic [1:0] {
		MUL_UU  = 2'b00,
		MUL_SS  = 2'b01,
		MULI_UU = 2'b10,
		MULI_SS = 2'b11
	} mulOp_t;

	// ======================================================================
	// operand side sizing
	// ======================================================================

	// default operand width, must divide by four
	localparam int DEFAULT_WID = 64;

	// one quarter of the multiplicand is consumed per step
	localparam int STEPS = 4;

endpackage
